// ==== Makefile ====
# Verilator build and run for the R5P SoC load/store subsystem
# Any variable below can be set on the make command line

VERILATOR ?= verilator
TOP       ?= r5p_soc_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= test passed

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: sim clean

# Build, run, then decide on the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
	  echo "simulation result found in $(LOG)"; \
	else \
	  echo "pass line not found in $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/r5p_ls_dec.sv ====
////////////////////////////////////////////////////////////
// R5P load/store decode stage
// Registers each request and steers it to the memory or
// the GPIO target by address bit 14
////////////////////////////////////////////////////////////

`default_nettype none

module r5p_ls_dec import r5p_soc_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // Load/store bus
  input  logic     ls_vld,
  input  ls_req_t  ls_req,
  // Target requests
  output tgt_req_t mem_req,
  output tgt_req_t gpio_req
);

  ////////////////////////////////////////////////////////////
  // Target select
  ////////////////////////////////////////////////////////////

  logic       sel_gpio;  // Bit 14, same place in both views
  logic [1:0] hit;       // One-hot, 0 memory and 1 GPIO

  assign sel_gpio = ls_req.adr.gpio.sel;
  assign hit      = {ls_vld & sel_gpio, ls_vld & ~sel_gpio};

  ////////////////////////////////////////////////////////////
  // Request registers
  ////////////////////////////////////////////////////////////

  tgt_req_t tgt_q [2];  // Indexed like hit

  always_ff @(posedge clk) begin
    for (int t = 0; t < 2; t++) begin
      // Valid flag is the only control state
      if (!rst_n) begin
        tgt_q[t].vld <= 1'b0;
      end else begin
        tgt_q[t].vld <= hit[t];  // Other target sees a bubble
      end
      // Payload follows its own target only
      if (hit[t]) begin
        tgt_q[t].wen <= ls_req.wen;
        tgt_q[t].adr <= ls_req.adr;
        tgt_q[t].ben <= ls_req.ben;
        tgt_q[t].wdt <= ls_req.wdt;
      end
    end
  end

  // Stale payload on the idle side is harmless, vld gates it
  assign mem_req  = tgt_q[0];
  assign gpio_req = tgt_q[1];

endmodule : r5p_ls_dec

`default_nettype wire

// ==== design/r5p_ls_rsp.sv ====
////////////////////////////////////////////////////////////
// R5P load/store response stage
// Tracks reads through the access stage and returns the
// selected target's data two cycles after the request
////////////////////////////////////////////////////////////

`default_nettype none

module r5p_ls_rsp import r5p_soc_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  // From the decode stage
  input  logic           dec_vld,
  input  logic           dec_wen,
  input  logic           dec_sel,   // Set for GPIO
  // Target read data
  input  logic [DDW-1:0] mem_rdt,
  input  logic [DDW-1:0] gpio_rdt,
  // Load/store response
  output logic           ls_rvld,
  output logic [DDW-1:0] ls_rdt
);

  ////////////////////////////////////////////////////////////
  // Access stage tracking
  ////////////////////////////////////////////////////////////

  logic acc_rd;   // Read under way in a target
  logic acc_sel;  // Which target holds its data

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_rd <= 1'b0;
    end else begin
      acc_rd <= dec_vld & ~dec_wen;  // Writes drop out here
    end
    acc_sel <= dec_sel;
  end

  ////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ls_rvld <= 1'b0;
    end else begin
      ls_rvld <= acc_rd;  // One pulse per read
    end
    if (acc_rd) begin
      ls_rdt <= acc_sel ? gpio_rdt : mem_rdt;
    end
  end

endmodule : r5p_ls_rsp

`default_nettype wire

// ==== design/r5p_soc_gpio.sv ====
////////////////////////////////////////////////////////////
// R5P SoC GPIO controller
// Output and enable registers with byte writes, and a
// two-flop synchronized input register
////////////////////////////////////////////////////////////

`default_nettype none

module r5p_soc_gpio import r5p_soc_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  // Decoded request
  input  tgt_req_t       gpio_req,
  output logic [DDW-1:0] gpio_rdt,
  // Pins
  output logic [GW-1:0]  gpio_o,
  output logic [GW-1:0]  gpio_e,
  input  logic [GW-1:0]  gpio_i
);

  ////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////

  logic [GPIO_RW-1:0] idx;  // Register index from the gpio view
  logic               wr;
  logic               rd;

  assign idx = gpio_req.adr.gpio.reg_idx;
  assign wr  = gpio_req.vld &  gpio_req.wen;
  assign rd  = gpio_req.vld & ~gpio_req.wen;

  ////////////////////////////////////////////////////////////
  // Input synchronizer
  ////////////////////////////////////////////////////////////

  logic [GW-1:0] gpio_s1;  // First stage, may go metastable
  logic [GW-1:0] gpio_s2;  // Stable copy

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gpio_s1 <= '0;
      gpio_s2 <= '0;
    end else begin
      gpio_s1 <= gpio_i;
      gpio_s2 <= gpio_s1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output and enable registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gpio_o <= '0;  // Pins released
      gpio_e <= '0;
    end else if (wr) begin
      for (int b = 0; b < DBW; b++) begin
        if (gpio_req.ben[b]) begin
          if (idx == GPIO_OUT) gpio_o[8*b +: 8] <= gpio_req.wdt[8*b +: 8];
          if (idx == GPIO_ENA) gpio_e[8*b +: 8] <= gpio_req.wdt[8*b +: 8];
          // Input register is read only
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read data
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rd) begin
      case (idx)
        GPIO_OUT: gpio_rdt <= gpio_o;
        GPIO_ENA: gpio_rdt <= gpio_e;
        GPIO_INP: gpio_rdt <= gpio_s2;  // Synchronized pins
        default:  gpio_rdt <= '0;       // Unmapped index
      endcase
    end
  end

endmodule : r5p_soc_gpio

`default_nettype wire

// ==== design/r5p_soc_mem.sv ====
////////////////////////////////////////////////////////////
// R5P SoC data memory
// 4096 words, byte-writable, one-cycle synchronous read
////////////////////////////////////////////////////////////

`default_nettype none

module r5p_soc_mem import r5p_soc_pkg::*; (
  input  logic           clk,
  // Decoded request
  input  tgt_req_t       mem_req,
  // Read data, one cycle after the request
  output logic [DDW-1:0] mem_rdt
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  logic [DDW-1:0] mem [2**MAW];  // Word array
  logic [MAW-1:0] wrd;           // Word index from the mem view
  logic           wr;
  logic           rd;

  assign wrd = mem_req.adr.mem.wrd;
  assign wr  = mem_req.vld &  mem_req.wen;
  assign rd  = mem_req.vld & ~mem_req.wen;

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr) begin
      for (int b = 0; b < DBW; b++) begin
        if (mem_req.ben[b]) begin
          mem[wrd][8*b +: 8] <= mem_req.wdt[8*b +: 8];  // Selected lanes only
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  // Power-up value zero
  logic [DDW-1:0] rdt_q = '0;

  always_ff @(posedge clk) begin
    if (rd) begin
      rdt_q <= mem[wrd];  // Holds between reads
    end
  end

  assign mem_rdt = rdt_q;

endmodule : r5p_soc_mem

`default_nettype wire

// ==== design/r5p_soc_pkg.sv ====
////////////////////////////////////////////////////////////
// R5P SoC load/store package
// Bus widths, GPIO register map, address views and the
// request structs used along the load/store path
////////////////////////////////////////////////////////////

`default_nettype none

package r5p_soc_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned DAW = 15;     // Data byte address
  localparam int unsigned DDW = 32;     // Data word
  localparam int unsigned DBW = DDW/8;  // Byte enables
  localparam int unsigned GW  = 32;     // GPIO pins
  localparam int unsigned MAW = 12;     // Memory word address, half the space

  // GPIO register map
  localparam int unsigned GPIO_RW = 2;  // Register index width
  localparam logic [GPIO_RW-1:0] GPIO_OUT = 2'd0;  // Output data
  localparam logic [GPIO_RW-1:0] GPIO_ENA = 2'd1;  // Output enable
  localparam logic [GPIO_RW-1:0] GPIO_INP = 2'd2;  // Synchronized input

  ////////////////////////////////////////////////////////////
  // Address views
  ////////////////////////////////////////////////////////////

  // Memory side, bit 14 clear
  typedef struct packed {
    logic                   sel;  // Target select
    logic [MAW-1:0]         wrd;  // Word index
    logic [$clog2(DBW)-1:0] off;  // Byte offset
  } ls_adr_mem_t;

  // GPIO side, bit 14 set
  typedef struct packed {
    logic                       sel;
    logic [DAW-1-GPIO_RW-3:0]   rsv;      // Unused, 10 bits
    logic [GPIO_RW-1:0]         reg_idx;  // Register select
    logic [$clog2(DBW)-1:0]     off;
  } ls_adr_gpio_t;

  // One address word, two decodings
  typedef union packed {
    ls_adr_mem_t  mem;
    ls_adr_gpio_t gpio;
  } ls_adr_u;

  ////////////////////////////////////////////////////////////
  // Requests
  ////////////////////////////////////////////////////////////

  // Load/store request from the core side
  typedef struct packed {
    logic           wen;  // Write when set
    ls_adr_u        adr;
    logic [DBW-1:0] ben;
    logic [DDW-1:0] wdt;
  } ls_req_t;

  // Decoded request toward one target
  typedef struct packed {
    logic           vld;
    logic           wen;
    ls_adr_u        adr;
    logic [DBW-1:0] ben;
    logic [DDW-1:0] wdt;
  } tgt_req_t;

endpackage : r5p_soc_pkg

`default_nettype wire

// ==== design/r5p_soc_top.sv ====
////////////////////////////////////////////////////////////
// R5P SoC load/store subsystem
// Decode, target access and response stages between the
// data bus and the data memory and GPIO
////////////////////////////////////////////////////////////

`default_nettype none

module r5p_soc_top import r5p_soc_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  // Load/store bus
  input  logic           ls_vld,
  input  ls_req_t        ls_req,
  output logic           ls_rvld,
  output logic [DDW-1:0] ls_rdt,
  // GPIO pins
  output logic [GW-1:0]  gpio_o,
  output logic [GW-1:0]  gpio_e,
  input  logic [GW-1:0]  gpio_i
);

  ////////////////////////////////////////////////////////////
  // Stage signals
  ////////////////////////////////////////////////////////////

  tgt_req_t       mem_req;   // Decode to memory
  tgt_req_t       gpio_req;  // Decode to GPIO
  logic [DDW-1:0] mem_rdt;
  logic [DDW-1:0] gpio_rdt;

  // Decode stage summary for the response stage
  wire dec_vld = mem_req.vld | gpio_req.vld;
  wire dec_sel = gpio_req.vld;
  wire dec_wen = (mem_req.vld & mem_req.wen) | (gpio_req.vld & gpio_req.wen);

  ////////////////////////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////////////////////////

  r5p_ls_dec ls_dec (
    .clk      (clk),
    .rst_n    (rst_n),
    .ls_vld   (ls_vld),
    .ls_req   (ls_req),
    .mem_req  (mem_req),
    .gpio_req (gpio_req)
  );

  // Targets work side by side
  r5p_soc_mem dmem (
    .clk     (clk),
    .mem_req (mem_req),
    .mem_rdt (mem_rdt)
  );

  r5p_soc_gpio soc_gpio (
    .clk      (clk),
    .rst_n    (rst_n),
    .gpio_req (gpio_req),
    .gpio_rdt (gpio_rdt),
    .gpio_o   (gpio_o),
    .gpio_e   (gpio_e),
    .gpio_i   (gpio_i)
  );

  r5p_ls_rsp ls_rsp (
    .clk      (clk),
    .rst_n    (rst_n),
    .dec_vld  (dec_vld),
    .dec_wen  (dec_wen),
    .dec_sel  (dec_sel),
    .mem_rdt  (mem_rdt),
    .gpio_rdt (gpio_rdt),
    .ls_rvld  (ls_rvld),
    .ls_rdt   (ls_rdt)
  );

endmodule : r5p_soc_top

`default_nettype wire

// ==== sources.f ====
design/r5p_soc_pkg.sv
design/r5p_ls_dec.sv
design/r5p_soc_mem.sv
design/r5p_soc_gpio.sv
design/r5p_ls_rsp.sv
design/r5p_soc_top.sv
tests/r5p_soc_checker.sv
tests/r5p_soc_tb.sv

// ==== tests/r5p_soc_checker.sv ====
////////////////////////////////////////////////////////////
// R5P SoC pipeline checker
// Read latency, reset behavior and target exclusivity
////////////////////////////////////////////////////////////

`default_nettype none

module r5p_soc_checker (
  input logic clk,
  input logic rst_n,
  input logic ls_vld,
  input logic ls_wen,
  input logic ls_rvld,
  input logic mem_vld,
  input logic gpio_vld
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;  // Summed into the testbench error count

  logic rd_req;
  assign rd_req = ls_vld & ~ls_wen;

  // Sampled at E0, ls_rvld loads at E2 and is seen one edge on
  a_rd_lat: assert property (@(posedge clk) disable iff (!rst_n) rd_req |-> ##3 ls_rvld)
    else begin
      fail_cnt++;
      $error("ls_rvld missing after a read request");
    end

  a_rd_src: assert property (@(posedge clk) disable iff (!rst_n) ls_rvld |-> $past(rd_req, 3))
    else begin
      fail_cnt++;
      $error("ls_rvld without a matching read request");
    end

  a_rst_low: assert property (@(posedge clk) !rst_n |=> !ls_rvld)
    else begin
      fail_cnt++;
      $error("ls_rvld high during reset");
    end

  a_one_tgt: assert property (@(posedge clk) disable iff (!rst_n) !(mem_vld && gpio_vld))
    else begin
      fail_cnt++;
      $error("memory and GPIO requests valid together");
    end

endmodule : r5p_soc_checker

// Watch the subsystem top from inside
bind r5p_soc_top r5p_soc_checker u_checker (
  .clk      (clk),
  .rst_n    (rst_n),
  .ls_vld   (ls_vld),
  .ls_wen   (ls_req.wen),
  .ls_rvld  (ls_rvld),
  .mem_vld  (mem_req.vld),
  .gpio_vld (gpio_req.vld)
);

`default_nettype wire

// ==== tests/r5p_soc_tb.sv ====
////////////////////////////////////////////////////////////
// R5P SoC load/store testbench
// Drives the data bus from a request table, checks read data
// in order and the GPIO pins against a pin model
////////////////////////////////////////////////////////////

`default_nettype none

module r5p_soc_tb import r5p_soc_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_P   = 4;      // ns
  localparam int RST_CYC = 8;
  localparam int RWIN    = 16;     // Random window, words
  localparam int RBASE   = 'h100;  // First word of the window
  localparam int RND_N   = 64;
  localparam logic [GW-1:0] PIN_IN = 32'hcafe_0001;  // gpio_i from the input test on

  // One table row, request plus expected read data
  typedef struct packed {
    logic           wen;
    logic [DAW-1:0] adr;
    logic [DBW-1:0] ben;
    logic [DDW-1:0] wdt;
    logic [GW-1:0]  gin;  // gpio_i while issuing
    logic [3:0]     gap;  // Idle cycles after
    logic [DDW-1:0] erd;  // Expected read data
  } op_t;

  logic           clk = 1'b0;
  logic           rst_n;
  logic           ls_vld;
  ls_req_t        ls_req;
  logic           ls_rvld;
  logic [DDW-1:0] ls_rdt;
  logic [GW-1:0]  gpio_o;
  logic [GW-1:0]  gpio_e;
  logic [GW-1:0]  gpio_i;

  op_t            ops [$];     // Stimulus table
  logic [DDW-1:0] exp_q [$];   // Reads in flight
  logic [GW-1:0]  pin_o = '0;  // Pin model
  logic [GW-1:0]  pin_e = '0;
  int             errors = 0;
  int             checks = 0;
  int             cyc = 0;
  int             limit = 0;

  always #(CLK_P/2) clk = ~clk;

  r5p_soc_top u_r5p_soc_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .ls_vld  (ls_vld),
    .ls_req  (ls_req),
    .ls_rvld (ls_rvld),
    .ls_rdt  (ls_rdt),
    .gpio_o  (gpio_o),
    .gpio_e  (gpio_e),
    .gpio_i  (gpio_i)
  );

  // New lanes where ben is set, old lanes elsewhere
  function automatic logic [DDW-1:0] merge_bytes(input logic [DDW-1:0] ow,
                                                 input logic [DDW-1:0] nw,
                                                 input logic [DBW-1:0] ben);
    logic [DDW-1:0] r;
    r = ow;
    for (int b = 0; b < DBW; b++) begin
      if (ben[b]) r[8*b +: 8] = nw[8*b +: 8];
    end
    return r;
  endfunction

  function automatic logic [DAW-1:0] win_adr(input int k);
    return DAW'((RBASE + k) * DBW);  // Bit 14 stays clear
  endfunction

  task automatic add_op(input logic wen, input logic [DAW-1:0] adr, input logic [DBW-1:0] ben,
                        input logic [DDW-1:0] wdt, input logic [GW-1:0] gin,
                        input logic [3:0] gap, input logic [DDW-1:0] erd);
    ops.push_back(op_t'({wen, adr, ben, wdt, gin, gap, erd}));
    if (wen && adr[DAW-1]) begin  // Only OUT and ENA hold state
      if (adr[3:2] == GPIO_OUT) pin_o = merge_bytes(pin_o, wdt, ben);
      if (adr[3:2] == GPIO_ENA) pin_e = merge_bytes(pin_e, wdt, ben);
    end
  endtask

  task automatic gen_random();
    logic [7:0]     mdl [RWIN*DBW];  // Byte-level memory model
    logic [DDW-1:0] d;
    logic [DDW-1:0] w;
    logic [DBW-1:0] b;
    int             i;
    for (int k = 0; k < RWIN; k++) begin  // Known contents first
      d = $urandom;
      for (int l = 0; l < DBW; l++) mdl[k*DBW+l] = d[8*l +: 8];
      add_op(1'b1, win_adr(k), 4'hf, d, PIN_IN, 4'd0, '0);
    end
    for (int n = 0; n < RND_N; n++) begin
      i = int'($urandom % RWIN);
      d = $urandom;
      b = DBW'($urandom);
      if ($urandom % 2 == 0) begin
        for (int l = 0; l < DBW; l++) begin
          if (b[l]) mdl[i*DBW+l] = d[8*l +: 8];
        end
        add_op(1'b1, win_adr(i), b, d, PIN_IN, 4'($urandom % 2), '0);
      end else begin
        for (int l = 0; l < DBW; l++) w[8*l +: 8] = mdl[i*DBW+l];
        add_op(1'b0, win_adr(i), 4'h0, 32'h0, PIN_IN, 4'($urandom % 2), w);
      end
    end
  endtask

  task automatic check_pins(input logic [GW-1:0] want_o, input logic [GW-1:0] want_e);
    checks += 2;
    if (gpio_o !== want_o) begin
      errors++;
      $display("[FAIL] gpio_o expected %h actual %h", want_o, gpio_o);
    end
    if (gpio_e !== want_e) begin
      errors++;
      $display("[FAIL] gpio_e expected %h actual %h", want_e, gpio_e);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Response monitor and run limit
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin  // Mid-cycle, outputs settled
    if (rst_n && ls_rvld) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ls_rvld pulsed while no read was outstanding");
      end else begin
        checks++;
        if (ls_rdt !== exp_q[0]) begin
          errors++;
          $display("[FAIL] ls_rdt expected %h actual %h", exp_q[0], ls_rdt);
        end
        void'(exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (limit > 0 && cyc >= limit) begin
      $display("run stopped at cycle %0d with %0d reads unanswered", cyc, exp_q.size());
      $display("test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(36159));
    rst_n  = 1'b0;
    ls_vld = 1'b0;
    ls_req = '0;
    gpio_i = '0;
    // Memory words, partial writes, reads on consecutive cycles
    add_op(1'b1, 15'h0000, 4'hf, 32'h1122_3344, 32'h0, 4'd0, 32'h0);
    add_op(1'b0, 15'h0000, 4'h0, 32'h0, 32'h0, 4'd1, 32'h1122_3344);
    add_op(1'b1, 15'h0004, 4'hf, 32'haabb_ccdd, 32'h0, 4'd0, 32'h0);
    add_op(1'b1, 15'h0004, 4'h5, 32'h00ee_00ff, 32'h0, 4'd0, 32'h0);
    add_op(1'b0, 15'h0004, 4'h0, 32'h0, 32'h0, 4'd0, 32'haaee_ccff);
    add_op(1'b1, 15'h0008, 4'hf, 32'h0102_0304, 32'h0, 4'd0, 32'h0);
    add_op(1'b0, 15'h0008, 4'h0, 32'h0, 32'h0, 4'd0, 32'h0102_0304);  // Just written
    add_op(1'b0, 15'h0000, 4'h0, 32'h0, 32'h0, 4'd0, 32'h1122_3344);
    add_op(1'b0, 15'h0004, 4'h0, 32'h0, 32'h0, 4'd1, 32'haaee_ccff);
    // GPIO output and enable, one byte lane
    add_op(1'b1, 15'h4000, 4'hf, 32'hdead_beef, 32'h0, 4'd0, 32'h0);
    add_op(1'b1, 15'h4004, 4'hf, 32'h0000_ffff, 32'h0, 4'd0, 32'h0);
    add_op(1'b1, 15'h4000, 4'h2, 32'h0000_5500, 32'h0, 4'd0, 32'h0);
    add_op(1'b0, 15'h4000, 4'h0, 32'h0, 32'h0, 4'd0, 32'hdead_55ef);
    add_op(1'b0, 15'h4004, 4'h0, 32'h0, 32'h0, 4'd1, 32'h0000_ffff);
    // Input register, pins settle during the gap
    add_op(1'b1, 15'h4008, 4'hf, 32'h1234_5678, PIN_IN, 4'd3, 32'h0);
    add_op(1'b0, 15'h4008, 4'h0, 32'h0, PIN_IN, 4'd0, PIN_IN);
    add_op(1'b0, 15'h400c, 4'h0, 32'h0, PIN_IN, 4'd0, 32'h0);  // Unmapped index
    // GPIO half leaves memory alone
    add_op(1'b1, 15'h400c, 4'hf, 32'h9999_9999, PIN_IN, 4'd0, 32'h0);
    add_op(1'b0, 15'h0000, 4'h0, 32'h0, PIN_IN, 4'd0, 32'h1122_3344);
    add_op(1'b0, 15'h0004, 4'h0, 32'h0, PIN_IN, 4'd0, 32'haaee_ccff);
    add_op(1'b0, 15'h4000, 4'h0, 32'h0, PIN_IN, 4'd1, 32'hdead_55ef);
    gen_random();
    limit = RST_CYC + 50;
    foreach (ops[k]) limit += 1 + int'(ops[k].gap);

    repeat (RST_CYC) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_pins(32'h0, 32'h0);
    foreach (ops[k]) begin
      @(posedge clk);
      ls_vld <= 1'b1;
      ls_req <= {ops[k].wen, ops[k].adr, ops[k].ben, ops[k].wdt};
      gpio_i <= ops[k].gin;
      if (!ops[k].wen) exp_q.push_back(ops[k].erd);
      repeat (ops[k].gap) begin
        @(posedge clk);
        ls_vld <= 1'b0;
      end
    end
    @(posedge clk);
    ls_vld <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);  // Room for a stray ls_rvld
    @(negedge clk);
    check_pins(pin_o, pin_e);

    errors += u_r5p_soc_top.u_checker.fail_cnt;
    $display("errors: %0d, assertion failures: %0d, checks: %0d",
             errors, u_r5p_soc_top.u_checker.fail_cnt, checks);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : r5p_soc_tb

`default_nettype wire
